//--- Bender.yml
package:
  name: ntsc_capture

sources:
  - verilog/ntsc_pkg.sv
  - verilog/ccir656_decoder.sv
  - verilog/pixel_packer.sv
  - verilog/pair_output_queue.sv
  - verilog/ntsc_capture.sv
  - target: simulation
    files:
      - dv/ntsc_capture_assertions.sv
      - dv/tb_ntsc_capture.sv

//--- dv/ntsc_capture_assertions.sv
`timescale 1ns/1ps

module ntsc_capture_assertions
  import ntsc_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input pixel_pair_t i_pair,
  input logic        i_req,
  input logic        i_ack,
  input logic        i_overflow
);

  // Number of failed handshake and queue checks
  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // Four-phase handshake on the queue output
  ////////////////////////////////////////////////////////////

  // Offered pair holds while req stays up
  pair_stable: assert property (@(posedge clk) disable iff (reset)
    i_req |=> (!i_req || $stable(i_pair)))
    else
    begin
      fail_count++;
      $error("o_pair changed while o_req was high");
    end

  // Req must stay until ack
  req_held: assert property (@(posedge clk) disable iff (reset)
    (i_req && !i_ack) |=> i_req)
    else
    begin
      fail_count++;
      $error("o_req fell without an ack");
    end

  // Req waits for ack low
  req_quiet: assert property (@(posedge clk) disable iff (reset)
    (!i_req && i_ack) |=> !i_req)
    else
    begin
      fail_count++;
      $error("o_req rose while i_ack was still high");
    end

  // Sticky flag
  overflow_sticky: assert property (@(posedge clk) disable iff (reset)
    i_overflow |=> i_overflow)
    else
    begin
      fail_count++;
      $error("o_overflow fell outside reset");
    end

endmodule

bind pair_output_queue ntsc_capture_assertions queue_checks (
  .clk        (clk),
  .reset      (reset),
  .i_pair     (o_pair),
  .i_req      (o_req),
  .i_ack      (i_ack),
  .i_overflow (o_overflow)
);

//--- dv/ntsc_stimulus.txt
# Columns: name field lines pixels_per_line ack_delay expected_pairs expected_overflow
# Lines count the active lines that follow one vertical blanking line
field0_basic    0   3   8   0  12  0
field1_basic    1   3   8   0  12  0
ack_delay1      0   3   8   1  12  0
long_line       0   2 700   0 640  0
long_line_f1    1   1 650   0 320  0
bottom_edge_f0  0 242   4   0 480  0
bottom_edge_f1  1 242   4   0 480  0
cut_line        0   3   7   0   9  0
cut_line_f1     1   2   5   0   4  0
slow_ack        0   3  64  20  96  1

//--- dv/tb_ntsc_capture.sv
`timescale 1ns/1ps

module tb_ntsc_capture
  import ntsc_pkg::*;
();

  logic        clk;
  logic        reset = 1'b1;
  video_word_t video = 10'h040;
  logic        ack = 1'b0;
  pixel_pair_t pair;
  logic        req;
  logic        overflow;

  // Test table from the stimulus file
  string t_name[$];
  int    t_field[$];
  int    t_lines[$];
  int    t_ppl[$];
  int    t_delay[$];
  int    t_pairs[$];
  int    t_ovf[$];

  // Model and consumer state
  pixel_pair_t exp_q[$];
  logic [31:0] rng;
  string       cur_name;
  int          ack_delay = 0;
  int          wait_cnt = 0;
  int          got_count;
  bit          subseq_mode;
  int          value_errors = 0;
  int          other_errors = 0;

  ntsc_capture dut (
    .clk        (clk),
    .reset      (reset),
    .i_video    (video),
    .i_ack      (ack),
    .o_pair     (pair),
    .o_req      (req),
    .o_overflow (overflow)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Stream helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v ^= v << 13;
    v ^= v >> 17;
    v ^= v << 5;
    return v;
  endfunction

  // Random data word that is never 000 or 3FF
  function automatic video_word_t next_word();
    rng = xorshift32(rng);
    return 10'h004 + video_word_t'(rng % 32'd1016);
  endfunction

  // XY word with its protection bits
  function automatic video_word_t xy_word(input logic f, input logic v, input logic h);
    return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h, 2'b00};
  endfunction

  task automatic send_word(input video_word_t w);
    @(posedge clk);
    video <= w;
  endtask

  task automatic send_code(input logic f, input logic v, input logic h);
    send_word(SYNC_PREAMBLE_FF);
    send_word(SYNC_PREAMBLE_00);
    send_word(SYNC_PREAMBLE_00);
    send_word(xy_word(f, v, h));
  endtask

  ////////////////////////////////////////////////////////////
  // Consumer side of the four-phase handshake
  ////////////////////////////////////////////////////////////

  task automatic check_pair(input pixel_pair_t got);
    pixel_pair_t want;
    got_count++;
    // With drops the delivered pairs only form a subsequence
    if (subseq_mode)
      while (exp_q.size() > 0 && exp_q[0] != got)
        void'(exp_q.pop_front());
    assert (exp_q.size() > 0)
    else
    begin
      other_errors++;
      $display("%s: pair %0d is a duplicate, out of order or was never sent",
               cur_name, got_count);
    end
    if (exp_q.size() > 0)
    begin
      want = exp_q.pop_front();
      assert (got == want)
      else
      begin
        value_errors++;
        $display("** Error %s: pair %0d expected %h actual %h", cur_name, got_count, want, got);
      end
    end
  endtask

  // Pair is taken when ack rises and ack falls once req is seen low
  always @(posedge clk)
  begin
    if (reset)
    begin
      ack      <= 1'b0;
      wait_cnt <= 0;
    end
    else if (req && !ack)
    begin
      if (wait_cnt >= ack_delay)
      begin
        check_pair(pair);
        ack      <= 1'b1;
        wait_cnt <= 0;
      end
      else
        wait_cnt <= wait_cnt + 1;
    end
    else if (ack && !req)
      ack <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // One test with reset, blanking line, active lines and drain
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int k);
    logic        f;
    int          j;
    int          i;
    int          yl;
    int          quiet;
    int          model_count;
    video_word_t c;
    video_word_t yw;
    video_word_t cb_m;
    video_word_t cr_m;
    pixel_t      pix;
    pixel_t      held_m;
    pixel_pair_t p;
    f           = (t_field[k] != 0);
    cur_name    = t_name[k];
    ack_delay   = t_delay[k];
    subseq_mode = (t_ovf[k] != 0);
    model_count = 0;
    got_count   = 0;
    exp_q.delete();
    @(posedge clk);
    reset <= 1'b1;
    video <= 10'h040;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // Load Cb and Cr once and let the vsync event clear the lone Y
    send_code(f, 1'b0, 1'b0);
    c = next_word();
    send_word(c);
    cb_m = c;
    send_word(next_word());
    c = next_word();
    send_word(c);
    cr_m = c;
    // Vertical blanking SAV with a pixel-like payload that is skipped
    send_code(f, 1'b1, 1'b0);
    repeat (8) send_word(next_word());
    send_code(f, 1'b1, 1'b1);
    for (j = 0; j < t_lines[k]; j++)
    begin
      yl = t_field[k] + 2 * j;
      send_code(f, 1'b0, 1'b0);
      for (i = 0; i < t_ppl[k]; i++)
      begin
        // Cb before even samples and Cr before odd ones
        c = next_word();
        send_word(c);
        if (i % 2 == 0)
          cb_m = c;
        else
          cr_m = c;
        yw = next_word();
        send_word(yw);
        pix = {yw[9:2], cr_m[9:5], cb_m[9:5]};
        if (yl < ACTIVE_HEIGHT && i < ACTIVE_WIDTH)
        begin
          if (i % 2 == 0)
            held_m = pix;
          else
          begin
            p.pix0 = held_m;
            p.pix1 = pix;
            p.x    = xcoord_t'(i - 1);
            p.y    = ycoord_t'(yl);
            exp_q.push_back(p);
            model_count++;
          end
        end
      end
      // An odd pixel count ends the line with 3FF in mid group
      send_code(f, 1'b0, 1'b1);
      send_word(10'h200);
      send_word(10'h040);
    end
    assert (model_count == t_pairs[k])
    else
    begin
      other_errors++;
      $display("%s: stimulus file lists %0d pairs but the stream holds %0d",
               cur_name, t_pairs[k], model_count);
    end
    // Drained once the handshake stays quiet for longer than one transfer
    quiet = 0;
    while (quiet < ack_delay + 8)
    begin
      @(posedge clk);
      if (req || ack)
        quiet = 0;
      else
        quiet++;
    end
    if (subseq_mode)
    begin
      assert (got_count <= t_pairs[k])
      else
      begin
        value_errors++;
        $display("** Error %s: at most %0d pairs expected, actual %0d",
                 cur_name, t_pairs[k], got_count);
      end
    end
    else
    begin
      assert (got_count == t_pairs[k])
      else
      begin
        value_errors++;
        $display("** Error %s: pair count expected %0d actual %0d",
                 cur_name, t_pairs[k], got_count);
      end
    end
    assert (overflow == (t_ovf[k] != 0))
    else
    begin
      value_errors++;
      $display("** Error %s: overflow expected %0d actual %0d", cur_name, t_ovf[k], overflow);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    int     fd;
    int     n;
    int     k;
    int     f;
    int     nl;
    int     ppl;
    int     dly;
    int     np;
    int     ovf;
    string  line;
    string  name;
    longint limit;
    rng   = 32'h3a3b;
    limit = 0;
    fd    = $fopen("dv/ntsc_stimulus.txt", "r");
    assert (fd != 0)
    else
    begin
      other_errors++;
      $display("Could not open dv/ntsc_stimulus.txt");
    end
    while (fd != 0 && !$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      // Skip comments and blank lines
      if (n > 0 && line.len() > 1 && line[0] != "#")
      begin
        n = $sscanf(line, "%s %d %d %d %d %d %d", name, f, nl, ppl, dly, np, ovf);
        if (n == 7)
        begin
          t_name.push_back(name);
          t_field.push_back(f);
          t_lines.push_back(nl);
          t_ppl.push_back(ppl);
          t_delay.push_back(dly);
          t_pairs.push_back(np);
          t_ovf.push_back(ovf);
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
    assert (t_name.size() > 0)
    else
    begin
      other_errors++;
      $display("No tests were found in the stimulus file");
    end
    // Twice the words of every stream plus one full transfer per pair
    for (k = 0; k < t_name.size(); k++)
      limit += 120 + t_lines[k] * (10 + 2 * t_ppl[k]) + t_pairs[k] * (t_delay[k] + 6);
    limit = 2 * limit + 100;
    fork
      begin
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit);
        $display("*** TEST FAILED ***");
        $finish;
      end
    join_none
    for (k = 0; k < t_name.size(); k++)
      run_test(k);
    other_errors += dut.result.queue_checks.fail_count;
    $display("Tests: %0d, value errors: %0d, other errors: %0d",
             t_name.size(), value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- src.f
verilog/ntsc_pkg.sv
verilog/ccir656_decoder.sv
verilog/pixel_packer.sv
verilog/pair_output_queue.sv
verilog/ntsc_capture.sv
dv/ntsc_capture_assertions.sv
dv/tb_ntsc_capture.sv

//--- verilog/ccir656_decoder.sv
`timescale 1ns/1ps

module ccir656_decoder
  import ntsc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  video_word_t i_video,
  output sync_event_t o_sync,
  output sample_t     o_sample
);

  decode_state_e state;
  decode_state_e state_next;

  // Latest luma and chroma words
  video_word_t y_q;
  video_word_t cr_q;
  video_word_t cb_q;

  logic sample_valid_q;
  logic is_ff;
  logic is_00;

  assign is_ff = (i_video == SYNC_PREAMBLE_FF);
  assign is_00 = (i_video == SYNC_PREAMBLE_00);

  ////////////////////////////////////////////////////////////
  // Stream FSM
  ////////////////////////////////////////////////////////////

  // Stream shape: 3FF 000 000 XY Cb Y Cr Y Cb Y ... 3FF 000 000 XY
  // The 3FF itself is consumed on the way into ST_SYNC_00A
  always_comb
  begin
    state_next = state;
    case (state)
      // Wait for the first 000 of the preamble
      ST_SYNC_00A: state_next = is_00 ? ST_SYNC_00B : ST_SYNC_00A;
      ST_SYNC_00B: state_next = is_00 ? ST_SYNC_XY : ST_SYNC_00A;
      // Classify the XY word, only the two active SAV codes open a line
      ST_SYNC_XY:
      begin
        if (i_video == SAV_ACTIVE_F0 || i_video == SAV_ACTIVE_F1)
          state_next = ST_CB;
        else
          state_next = ST_SKIP;
      end
      // Active samples, a 3FF anywhere restarts the preamble search
      ST_CB:   state_next = is_ff ? ST_SYNC_00A : ST_Y0;
      ST_Y0:   state_next = is_ff ? ST_SYNC_00A : ST_CR;
      ST_CR:   state_next = is_ff ? ST_SYNC_00A : ST_Y1;
      ST_Y1:   state_next = is_ff ? ST_SYNC_00A : ST_CB;
      // EAV and blanking codes carry no samples
      ST_SKIP: state_next = ST_SYNC_00A;
      default: state_next = ST_SYNC_00A;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state          <= ST_SYNC_00A;
      o_sync         <= '0;
      sample_valid_q <= 1'b0;
    end
    else
    begin
      state <= state_next;
      // Sync pulse in the cycle after the XY word
      o_sync <= '0;
      if (state == ST_SYNC_XY)
      begin
        o_sync.field <= i_video[XY_F_BIT];
        o_sync.vsync <= i_video[XY_V_BIT];
        o_sync.hsync <= i_video[XY_H_BIT];
      end
      // One sample per Y word
      sample_valid_q <= (state == ST_Y0 || state == ST_Y1) && !is_ff;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sample registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if ((state == ST_Y0 || state == ST_Y1) && !is_ff)
      y_q <= i_video;
    if (state == ST_CR && !is_ff)
      cr_q <= i_video;
    if (state == ST_CB && !is_ff)
      cb_q <= i_video;
  end

  // Keep 8 bits of luma and 5 of each chroma
  assign o_sample.valid = sample_valid_q;
  assign o_sample.pixel = {y_q[9:2], cr_q[9:5], cb_q[9:5]};

endmodule

//--- verilog/ntsc_capture.sv
`timescale 1ns/1ps

module ntsc_capture
  import ntsc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  video_word_t i_video,
  input  logic        i_ack,
  output pixel_pair_t o_pair,
  output logic        o_req,
  output logic        o_overflow
);

  // Decoder to packer
  sync_event_t decode_sync;
  sample_t     decode_sample;

  // Packer to queue
  pixel_pair_t packer_pair;
  logic        packer_pair_valid;

  ////////////////////////////////////////////////////////////
  // Decode, execute, result
  ////////////////////////////////////////////////////////////

  ccir656_decoder decode (
    .clk      (clk),
    .reset    (reset),
    .i_video  (i_video),
    .o_sync   (decode_sync),
    .o_sample (decode_sample)
  );

  pixel_packer execute (
    .clk          (clk),
    .reset        (reset),
    .i_sync       (decode_sync),
    .i_sample     (decode_sample),
    .o_pair       (packer_pair),
    .o_pair_valid (packer_pair_valid)
  );

  // Absorbs consumer latency, drops on full
  pair_output_queue result (
    .clk          (clk),
    .reset        (reset),
    .i_pair       (packer_pair),
    .i_pair_valid (packer_pair_valid),
    .i_ack        (i_ack),
    .o_pair       (o_pair),
    .o_req        (o_req),
    .o_overflow   (o_overflow)
  );

endmodule

//--- verilog/ntsc_pkg.sv
package ntsc_pkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////

  // One word of the 10-bit CCIR656 stream
  typedef logic [9:0] video_word_t;
  // Y[9:2], Cr[9:5], Cb[9:5] packed high to low
  typedef logic [17:0] pixel_t;
  // Column and row inside the capture window
  typedef logic [9:0] xcoord_t;
  typedef logic [8:0] ycoord_t;

  ////////////////////////////////////////////////////////////
  // Window, queue and timing code constants
  ////////////////////////////////////////////////////////////

  localparam int unsigned ACTIVE_WIDTH  = 640;
  localparam int unsigned ACTIVE_HEIGHT = 480;
  localparam int unsigned QUEUE_DEPTH   = 4;

  // Preamble words ahead of every XY code
  localparam video_word_t SYNC_PREAMBLE_FF = 10'h3FF;
  localparam video_word_t SYNC_PREAMBLE_00 = 10'h000;
  // Start of active video, field 0 and field 1
  localparam video_word_t SAV_ACTIVE_F0 = 10'h200;
  localparam video_word_t SAV_ACTIVE_F1 = 10'h31C;

  // Bit positions of F, V and H inside the XY word
  localparam int unsigned XY_F_BIT = 8;
  localparam int unsigned XY_V_BIT = 7;
  localparam int unsigned XY_H_BIT = 6;

  ////////////////////////////////////////////////////////////
  // Structs passed between the stages
  ////////////////////////////////////////////////////////////

  // F, V and H of one XY word, pulsed for a single cycle
  typedef struct packed {
    logic field;
    logic vsync;
    logic hsync;
  } sync_event_t;

  // One Y sample with the latest chroma
  typedef struct packed {
    logic   valid;
    pixel_t pixel;
  } sample_t;

  // Two neighbouring pixels, x is the column of pix0
  typedef struct packed {
    pixel_t  pix0;
    pixel_t  pix1;
    xcoord_t x;
    ycoord_t y;
  } pixel_pair_t;

  // Decoder FSM: three sync states, four sample states, one skip
  typedef enum logic [2:0] {
    ST_SYNC_00A,
    ST_SYNC_00B,
    ST_SYNC_XY,
    ST_CB,
    ST_Y0,
    ST_CR,
    ST_Y1,
    ST_SKIP
  } decode_state_e;

endpackage

//--- verilog/pair_output_queue.sv
`timescale 1ns/1ps

module pair_output_queue
  import ntsc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  pixel_pair_t i_pair,
  input  logic        i_pair_valid,
  input  logic        i_ack,
  output pixel_pair_t o_pair,
  output logic        o_req,
  output logic        o_overflow
);

  typedef logic [$clog2(QUEUE_DEPTH)-1:0]   qptr_t;
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] qcount_t;

  // Four-phase output handshake
  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,
    HS_WAIT_LOW
  } hs_state_e;

  pixel_pair_t mem [QUEUE_DEPTH];
  qptr_t       wr_ptr;
  qptr_t       rd_ptr;
  qcount_t     count;
  hs_state_e   hs_state;
  hs_state_e   hs_next;

  logic full;
  logic push;
  logic pop;

  // Pointer step with wrap at the last entry
  function automatic qptr_t ptr_inc(input qptr_t ptr);
    if (ptr == qptr_t'(QUEUE_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full = (count == qcount_t'(QUEUE_DEPTH));
  assign push = i_pair_valid && !full;
  // Item leaves when the consumer acknowledges it
  assign pop  = (hs_state == HS_REQ) && i_ack;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= i_pair;
  end

  // Head entry is never overwritten while it is offered
  assign o_pair = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
      hs_state   <= HS_IDLE;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + qcount_t'(push) - qcount_t'(pop);
      // Sticky until reset, the video source cannot be held off
      if (i_pair_valid && full)
        o_overflow <= 1'b1;
      hs_state <= hs_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    hs_next = hs_state;
    case (hs_state)
      HS_IDLE:     if (count != '0 || push) hs_next = HS_REQ;
      HS_REQ:      if (i_ack) hs_next = HS_WAIT_LOW;
      // Next request only once ack has been seen low
      HS_WAIT_LOW: if (!i_ack) hs_next = (count != '0 || push) ? HS_REQ : HS_IDLE;
      default:     hs_next = HS_IDLE;
    endcase
  end

  assign o_req = (hs_state == HS_REQ);

endmodule

//--- verilog/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer
  import ntsc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  sync_event_t i_sync,
  input  sample_t     i_sample,
  output pixel_pair_t o_pair,
  output logic        o_pair_valid
);

  // Current position of the next sample
  xcoord_t x;
  ycoord_t y;

  // First pixel of the pair being built
  pixel_t held_pixel;

  logic in_window;
  logic take_sample;

  assign in_window   = (y < ycoord_t'(ACTIVE_HEIGHT)) && (x < xcoord_t'(ACTIVE_WIDTH));
  assign take_sample = i_sample.valid && in_window;

  ////////////////////////////////////////////////////////////
  // Coordinate counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      x <= '0;
      y <= '0;
    end
    else if (i_sync.vsync)
    begin
      // Vertical blanking restarts the field on row 0 or 1
      y <= ycoord_t'(i_sync.field);
      x <= '0;
    end
    else if (i_sync.hsync)
    begin
      // Interlaced, so each field steps by two rows
      // Held once below the window so the row cannot wrap back in
      if (y < ycoord_t'(ACTIVE_HEIGHT))
        y <= y + 9'd2;
      x <= '0;
    end
    else if (take_sample)
    begin
      x <= x + 10'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pair assembly
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
      o_pair_valid <= 1'b0;
    else
      o_pair_valid <= take_sample && x[0];
  end

  // Even column is held, odd column closes the pair
  always_ff @(posedge clk)
  begin
    if (take_sample && !x[0])
      held_pixel <= i_sample.pixel;
    if (take_sample && x[0])
    begin
      o_pair.pix0 <= held_pixel;
      o_pair.pix1 <= i_sample.pixel;
      // Column of the held pixel
      o_pair.x    <= x - 10'd1;
      o_pair.y    <= y;
    end
  end

endmodule
